/* rtl/cr_map_pkg.sv */
package cr_map_pkg;

    typedef logic [15:0] cr_addr_t;                // CR word address
    typedef logic [31:0] cr_data_t;                // Register word

    localparam int NUM_SCRATCH = 4;

    // ==================================================
    // Single registers
    // ==================================================
    localparam cr_addr_t WHO_AM_I           = 16'h000;  // Core id and thread id
    localparam cr_addr_t THREAD_ID          = 16'h001;
    localparam cr_addr_t CORE_ID            = 16'h002;
    localparam cr_addr_t STACK_BASE_OFFSET  = 16'h003;  // Current thread stack offset
    localparam cr_addr_t TLS_BASE_OFFSET    = 16'h004;  // Current thread TLS offset
    localparam cr_addr_t SHARED_BASE_OFFSET = 16'h005;
    localparam cr_addr_t I_MEM_MSB          = 16'h006;
    localparam cr_addr_t D_MEM_MSB          = 16'h007;

    // ==================================================
    // Four-entry groups, entry n sits at base plus n
    // ==================================================
    localparam cr_addr_t THREAD0_PC_RST       = 16'h010;
    localparam cr_addr_t THREAD0_PC_EN        = 16'h014;
    localparam cr_addr_t THREAD0_STACK_OFFSET = 16'h018;
    localparam cr_addr_t THREAD0_TLS_OFFSET   = 16'h01C;
    localparam cr_addr_t THREAD0_PC           = 16'h020;  // Sampled PC, read only
    localparam cr_addr_t SCRATCHPAD0          = 16'h024;

    localparam cr_data_t SHARED_OFFSET_RST = 32'h0040_0F00;

endpackage

/* rtl/thread_pkg.sv */
package thread_pkg;

    localparam int NUM_THREADS = 4;

    typedef logic [$clog2(NUM_THREADS)-1:0] thread_id_t;
    typedef logic [NUM_THREADS-1:0]         thread_oh_t;  // One-hot thread select

    // Per-thread offset reset values, thread 0 first
    localparam logic [31:0] STACK_OFFSET_RST [NUM_THREADS] = '{
        32'h0040_0200, 32'h0040_0400, 32'h0040_0600, 32'h0040_0800
    };
    localparam logic [31:0] TLS_OFFSET_RST [NUM_THREADS] = '{
        32'h0040_0200, 32'h0040_0400, 32'h0040_0600, 32'h0040_0800
    };

endpackage

/* rtl/thread_reg_bank.sv */
`timescale 1ns/1ps

module thread_reg_bank #(
    parameter type payload_t = logic,
    parameter payload_t RST_VALS [thread_pkg::NUM_THREADS] = '{default: '0}
) (
    input  logic                               qclk,
    input  logic                               reset,
    input  logic [thread_pkg::NUM_THREADS-1:0] we,
    input  payload_t                           core_word,
    input  payload_t                           ring_word,
    input  logic [thread_pkg::NUM_THREADS-1:0] ring_sel,
    output payload_t                           q [thread_pkg::NUM_THREADS]
);
    import thread_pkg::*;

    always_ff @(posedge qclk) begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (reset) begin
                q[i] <= RST_VALS[i];
            end else if (we[i]) begin
                q[i] <= ring_sel[i] ? ring_word : core_word;  // Ring wins a collision
            end
        end
    end

endmodule

/* rtl/cr_write_decode.sv */
`timescale 1ns/1ps

module cr_write_decode (
    input  cr_map_pkg::cr_addr_t               core_addr,
    input  logic                               core_wr_en,
    input  cr_map_pkg::cr_data_t               core_wr_data,
    input  cr_map_pkg::cr_addr_t               ring_addr,
    input  logic                               ring_wr_en,
    input  cr_map_pkg::cr_data_t               ring_wr_data,
    output logic [thread_pkg::NUM_THREADS-1:0] rst_pc_we,
    output logic [thread_pkg::NUM_THREADS-1:0] en_pc_we,
    output logic [thread_pkg::NUM_THREADS-1:0] stk_we,
    output logic [thread_pkg::NUM_THREADS-1:0] tls_we,
    output logic [cr_map_pkg::NUM_SCRATCH-1:0] scratch_we,
    output logic                               shared_we,
    output logic [thread_pkg::NUM_THREADS-1:0] rst_pc_rsel,
    output logic [thread_pkg::NUM_THREADS-1:0] en_pc_rsel,
    output logic [thread_pkg::NUM_THREADS-1:0] stk_rsel,
    output logic [thread_pkg::NUM_THREADS-1:0] tls_rsel,
    output logic [cr_map_pkg::NUM_SCRATCH:0]   gen_rsel,     // Scratch pads, then shared
    output cr_map_pkg::cr_data_t               wr_word,
    output cr_map_pkg::cr_data_t               core_wr_word
);
    import cr_map_pkg::*;
    import thread_pkg::*;

    localparam int NUM_GRP = 5;
    localparam int EN_W    = 4 * NUM_THREADS + NUM_SCRATCH + 1;
    localparam cr_addr_t GRP_BASE [NUM_GRP] = '{
        THREAD0_PC_RST, THREAD0_PC_EN, THREAD0_STACK_OFFSET, THREAD0_TLS_OFFSET, SCRATCHPAD0
    };

    logic [EN_W-1:0] core_en;
    logic [EN_W-1:0] ring_en;
    logic [EN_W-1:0] all_en;

    // One bit per writable register, groups of four then shared on top
    function automatic logic [EN_W-1:0] decode(input cr_addr_t addr, input logic we);
        logic [EN_W-1:0] en;
        en = '0;
        if (we) begin
            for (int g = 0; g < NUM_GRP; g++) begin
                if (addr[15:2] == GRP_BASE[g][15:2]) begin
                    en[g * NUM_THREADS + int'(addr[1:0])] = 1'b1;
                end
            end
            if (addr == SHARED_BASE_OFFSET) begin
                en[EN_W-1] = 1'b1;
            end
        end
        return en;
    endfunction

    assign core_en = decode(core_addr, core_wr_en);
    assign ring_en = decode(ring_addr, ring_wr_en);
    assign all_en  = core_en | ring_en;

    assign rst_pc_we  = all_en[0 +: NUM_THREADS];
    assign en_pc_we   = all_en[NUM_THREADS +: NUM_THREADS];
    assign stk_we     = all_en[2 * NUM_THREADS +: NUM_THREADS];
    assign tls_we     = all_en[3 * NUM_THREADS +: NUM_THREADS];
    assign scratch_we = all_en[4 * NUM_THREADS +: NUM_SCRATCH];
    assign shared_we  = all_en[EN_W-1];

    assign rst_pc_rsel = ring_en[0 +: NUM_THREADS];       // Register written by ring
    assign en_pc_rsel  = ring_en[NUM_THREADS +: NUM_THREADS];
    assign stk_rsel    = ring_en[2 * NUM_THREADS +: NUM_THREADS];
    assign tls_rsel    = ring_en[3 * NUM_THREADS +: NUM_THREADS];
    assign gen_rsel    = ring_en[4 * NUM_THREADS +: NUM_SCRATCH + 1];

    assign wr_word      = (|ring_en) ? ring_wr_data : core_wr_data;
    assign core_wr_word = core_wr_data;

endmodule

/* rtl/thread_snapshot.sv */
`timescale 1ns/1ps

module thread_snapshot (
    input  logic                   qclk,
    input  logic                   reset,
    input  thread_pkg::thread_oh_t thread,
    input  cr_map_pkg::cr_data_t   pc,
    input  cr_map_pkg::cr_data_t   stk [thread_pkg::NUM_THREADS],
    input  cr_map_pkg::cr_data_t   tls [thread_pkg::NUM_THREADS],
    output thread_pkg::thread_id_t thread_id,
    output cr_map_pkg::cr_data_t   cur_stk,
    output cr_map_pkg::cr_data_t   cur_tls,
    output cr_map_pkg::cr_data_t   pc_q [thread_pkg::NUM_THREADS]
);
    import thread_pkg::*;

    thread_oh_t cur_oh;
    thread_id_t cur_id;

    // The CR stage sits one thread ahead of the incoming select
    assign cur_oh = {thread[NUM_THREADS-2:0], thread[NUM_THREADS-1]};

    always_comb begin
        cur_id = thread_id_t'(NUM_THREADS - 1);          // Non one-hot falls to last thread
        for (int k = 0; k < NUM_THREADS - 1; k++) begin
            if (cur_oh == thread_oh_t'(1 << k)) begin
                cur_id = thread_id_t'(k);
            end
        end
    end

    always_ff @(posedge qclk) begin
        if (reset) begin
            thread_id <= '0;
            cur_stk   <= '0;
            cur_tls   <= '0;
        end else begin
            thread_id <= cur_id;
            cur_stk   <= stk[cur_id];
            cur_tls   <= tls[cur_id];
        end
    end

    always_ff @(posedge qclk) begin
        if (reset) begin
            for (int k = 0; k < NUM_THREADS; k++) begin
                pc_q[k] <= '0;
            end
        end else begin
            pc_q[cur_id] <= pc;                          // Round robin as threads rotate
        end
    end

endmodule

/* rtl/cr_general_regs.sv */
`timescale 1ns/1ps

module cr_general_regs (
    input  logic                               qclk,
    input  logic                               reset,
    input  logic [cr_map_pkg::NUM_SCRATCH-1:0] scratch_we,
    input  logic                               shared_we,
    input  logic [cr_map_pkg::NUM_SCRATCH:0]   ring_sel,   // Top bit for shared offset
    input  cr_map_pkg::cr_data_t               core_word,
    input  cr_map_pkg::cr_data_t               ring_word,
    output cr_map_pkg::cr_data_t               scratch [cr_map_pkg::NUM_SCRATCH],
    output cr_map_pkg::cr_data_t               shared
);
    import cr_map_pkg::*;

    always_ff @(posedge qclk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
            shared <= SHARED_OFFSET_RST;
        end else begin
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                if (scratch_we[i]) begin
                    scratch[i] <= ring_sel[i] ? ring_word : core_word;
                end
            end
            if (shared_we) begin
                shared <= ring_sel[NUM_SCRATCH] ? ring_word : core_word;
            end
        end
    end

endmodule

/* rtl/cr_read_port.sv */
`timescale 1ns/1ps

module cr_read_port #(
    parameter logic [7:0] MSB_I_MEM = 8'h3F,
    parameter logic [7:0] MSB_D_MEM = 8'h7F
) (
    input  logic                               qclk,
    input  logic                               reset,
    input  logic                               rd_en,
    input  cr_map_pkg::cr_addr_t               addr,
    input  logic [7:0]                         core_id,
    input  thread_pkg::thread_id_t             thread_id,
    input  cr_map_pkg::cr_data_t               cur_stk,
    input  cr_map_pkg::cr_data_t               cur_tls,
    input  cr_map_pkg::cr_data_t               shared,
    input  logic [thread_pkg::NUM_THREADS-1:0] rst_pc,
    input  logic [thread_pkg::NUM_THREADS-1:0] en_pc,
    input  cr_map_pkg::cr_data_t               stk [thread_pkg::NUM_THREADS],
    input  cr_map_pkg::cr_data_t               tls [thread_pkg::NUM_THREADS],
    input  cr_map_pkg::cr_data_t               pc_q [thread_pkg::NUM_THREADS],
    input  cr_map_pkg::cr_data_t               scratch [cr_map_pkg::NUM_SCRATCH],
    output cr_map_pkg::cr_data_t               rd_data
);
    import cr_map_pkg::*;
    import thread_pkg::*;

    thread_id_t idx;
    cr_data_t   rd_word;

    assign idx = addr[1:0];                              // Entry within a group of four

    // ==================================================
    // Address select
    // ==================================================
    always_comb begin
        rd_word = '0;                                    // Quiet or unmapped reads give zero
        if (rd_en) begin
            case (addr)
                WHO_AM_I:           rd_word = cr_data_t'({core_id, thread_id});
                THREAD_ID:          rd_word = cr_data_t'(thread_id);
                CORE_ID:            rd_word = cr_data_t'(core_id);
                STACK_BASE_OFFSET:  rd_word = cur_stk;
                TLS_BASE_OFFSET:    rd_word = cur_tls;
                SHARED_BASE_OFFSET: rd_word = shared;
                I_MEM_MSB:          rd_word = cr_data_t'(MSB_I_MEM);
                D_MEM_MSB:          rd_word = cr_data_t'(MSB_D_MEM);
                default: begin
                    if (addr[15:2] == THREAD0_PC_RST[15:2]) begin
                        rd_word = cr_data_t'(rst_pc[idx]);
                    end else if (addr[15:2] == THREAD0_PC_EN[15:2]) begin
                        rd_word = cr_data_t'(en_pc[idx]);
                    end else if (addr[15:2] == THREAD0_STACK_OFFSET[15:2]) begin
                        rd_word = stk[idx];
                    end else if (addr[15:2] == THREAD0_TLS_OFFSET[15:2]) begin
                        rd_word = tls[idx];
                    end else if (addr[15:2] == THREAD0_PC[15:2]) begin
                        rd_word = pc_q[idx];
                    end else if (addr[15:2] == SCRATCHPAD0[15:2]) begin
                        rd_word = scratch[idx];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge qclk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_word;                          // Data one cycle after the strobe
        end
    end

endmodule

/* rtl/cr_mem.sv */
`timescale 1ns/1ps

module cr_mem #(
    parameter logic [7:0] MSB_I_MEM = 8'h3F,
    parameter logic [7:0] MSB_D_MEM = 8'h7F
) (
    input  logic                               qclk,
    input  logic                               reset,
    input  logic [7:0]                         core_id,      // Strap
    input  cr_map_pkg::cr_addr_t               core_addr,
    input  cr_map_pkg::cr_data_t               core_wr_data,
    input  logic                               core_rd_en,
    input  logic                               core_wr_en,
    output cr_map_pkg::cr_data_t               core_rd_data,
    input  thread_pkg::thread_oh_t             thread,
    input  cr_map_pkg::cr_data_t               pc,
    input  cr_map_pkg::cr_addr_t               ring_addr,
    input  cr_map_pkg::cr_data_t               ring_wr_data,
    input  logic                               ring_rd_en,
    input  logic                               ring_wr_en,
    output cr_map_pkg::cr_data_t               ring_rd_data,
    output logic [thread_pkg::NUM_THREADS-1:0] rst_pc,
    output logic [thread_pkg::NUM_THREADS-1:0] en_pc
);
    import cr_map_pkg::*;
    import thread_pkg::*;

    localparam logic RST_PC_INIT [NUM_THREADS] = '{default: 1'b0};
    localparam logic EN_PC_INIT  [NUM_THREADS] = '{default: 1'b1};  // Threads run after reset

    logic [NUM_THREADS-1:0] rst_pc_we;
    logic [NUM_THREADS-1:0] en_pc_we;
    logic [NUM_THREADS-1:0] stk_we;
    logic [NUM_THREADS-1:0] tls_we;
    logic [NUM_THREADS-1:0] rst_pc_rsel;
    logic [NUM_THREADS-1:0] en_pc_rsel;
    logic [NUM_THREADS-1:0] stk_rsel;
    logic [NUM_THREADS-1:0] tls_rsel;
    logic [NUM_SCRATCH-1:0] scratch_we;
    logic [NUM_SCRATCH:0]   gen_rsel;
    logic                   shared_we;
    cr_data_t               wr_word;
    cr_data_t               core_wr_word;
    logic                   rst_pc_q [NUM_THREADS];
    logic                   en_pc_q [NUM_THREADS];
    cr_data_t               stk [NUM_THREADS];
    cr_data_t               tls [NUM_THREADS];
    cr_data_t               pc_q [NUM_THREADS];
    cr_data_t               scratch [NUM_SCRATCH];
    cr_data_t               shared;
    cr_data_t               cur_stk;
    cr_data_t               cur_tls;
    thread_id_t             thread_id;

    // ==================================================
    // Write side
    // ==================================================
    cr_write_decode wr_dec_i (
        .core_addr(core_addr), .core_wr_en(core_wr_en), .core_wr_data(core_wr_data),
        .ring_addr(ring_addr), .ring_wr_en(ring_wr_en), .ring_wr_data(ring_wr_data),
        .rst_pc_we(rst_pc_we), .en_pc_we(en_pc_we), .stk_we(stk_we), .tls_we(tls_we),
        .scratch_we(scratch_we), .shared_we(shared_we),
        .rst_pc_rsel(rst_pc_rsel), .en_pc_rsel(en_pc_rsel),
        .stk_rsel(stk_rsel), .tls_rsel(tls_rsel), .gen_rsel(gen_rsel),
        .wr_word(wr_word), .core_wr_word(core_wr_word)
    );

    thread_reg_bank #(.payload_t(logic), .RST_VALS(RST_PC_INIT)) rst_pc_bank_i (
        .qclk(qclk), .reset(reset), .we(rst_pc_we), .core_word(core_wr_word[0]),
        .ring_word(wr_word[0]), .ring_sel(rst_pc_rsel), .q(rst_pc_q)
    );

    thread_reg_bank #(.payload_t(logic), .RST_VALS(EN_PC_INIT)) en_pc_bank_i (
        .qclk(qclk), .reset(reset), .we(en_pc_we), .core_word(core_wr_word[0]),
        .ring_word(wr_word[0]), .ring_sel(en_pc_rsel), .q(en_pc_q)
    );

    thread_reg_bank #(.payload_t(cr_data_t), .RST_VALS(STACK_OFFSET_RST)) stk_bank_i (
        .qclk(qclk), .reset(reset), .we(stk_we), .core_word(core_wr_word),
        .ring_word(wr_word), .ring_sel(stk_rsel), .q(stk)
    );

    thread_reg_bank #(.payload_t(cr_data_t), .RST_VALS(TLS_OFFSET_RST)) tls_bank_i (
        .qclk(qclk), .reset(reset), .we(tls_we), .core_word(core_wr_word),
        .ring_word(wr_word), .ring_sel(tls_rsel), .q(tls)
    );

    cr_general_regs gen_regs_i (
        .qclk(qclk), .reset(reset), .scratch_we(scratch_we), .shared_we(shared_we),
        .ring_sel(gen_rsel), .core_word(core_wr_word), .ring_word(wr_word),
        .scratch(scratch), .shared(shared)
    );

    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            rst_pc[i] = rst_pc_q[i];                     // Flag banks drive the core
            en_pc[i]  = en_pc_q[i];
        end
    end

    // ==================================================
    // Thread tracking and read side
    // ==================================================
    thread_snapshot snap_i (
        .qclk(qclk), .reset(reset), .thread(thread), .pc(pc), .stk(stk), .tls(tls),
        .thread_id(thread_id), .cur_stk(cur_stk), .cur_tls(cur_tls), .pc_q(pc_q)
    );

    cr_read_port #(.MSB_I_MEM(MSB_I_MEM), .MSB_D_MEM(MSB_D_MEM)) core_rd_port_i (
        .qclk(qclk), .reset(reset), .rd_en(core_rd_en), .addr(core_addr),
        .core_id(core_id), .thread_id(thread_id), .cur_stk(cur_stk), .cur_tls(cur_tls),
        .shared(shared), .rst_pc(rst_pc), .en_pc(en_pc), .stk(stk), .tls(tls),
        .pc_q(pc_q), .scratch(scratch), .rd_data(core_rd_data)
    );

    cr_read_port #(.MSB_I_MEM(MSB_I_MEM), .MSB_D_MEM(MSB_D_MEM)) ring_rd_port_i (
        .qclk(qclk), .reset(reset), .rd_en(ring_rd_en), .addr(ring_addr),
        .core_id(core_id), .thread_id(thread_id), .cur_stk(cur_stk), .cur_tls(cur_tls),
        .shared(shared), .rst_pc(rst_pc), .en_pc(en_pc), .stk(stk), .tls(tls),
        .pc_q(pc_q), .scratch(scratch), .rd_data(ring_rd_data)
    );

endmodule

/* verification/cr_mem_chk.sv */
`timescale 1ns/1ps

module cr_mem_chk (
    input logic                               qclk,
    input logic                               reset,
    input cr_map_pkg::cr_addr_t               core_addr,
    input cr_map_pkg::cr_data_t               core_wr_data,
    input logic                               core_rd_en,
    input logic                               core_wr_en,
    input cr_map_pkg::cr_data_t               core_rd_data,
    input cr_map_pkg::cr_addr_t               ring_addr,
    input cr_map_pkg::cr_data_t               ring_wr_data,
    input logic                               ring_rd_en,
    input logic                               ring_wr_en,
    input cr_map_pkg::cr_data_t               ring_rd_data,
    input logic [thread_pkg::NUM_THREADS-1:0] rst_pc,
    input logic [thread_pkg::NUM_THREADS-1:0] en_pc
);
    import cr_map_pkg::*;

    logic       flags_written;
    logic       core_flag_wr;                            // Core flag write not hit by the ring
    logic       ring_flag_wr;
    logic       core_rd_live;
    logic       ring_rd_live;
    logic [7:0] flags;                                   // Enable flags above reset flags

    function automatic logic is_mapped(input cr_addr_t addr);
        return (addr <= D_MEM_MSB) || (addr >= THREAD0_PC_RST && addr <= SCRATCHPAD0 + 16'd3);
    endfunction

    assign core_flag_wr = core_wr_en && core_addr[15:3] == THREAD0_PC_RST[15:3]
                          && !(ring_wr_en && ring_addr == core_addr);
    assign ring_flag_wr = ring_wr_en && ring_addr[15:3] == THREAD0_PC_RST[15:3];
    assign core_rd_live = core_rd_en && is_mapped(core_addr);
    assign ring_rd_live = ring_rd_en && is_mapped(ring_addr);
    assign flags        = {en_pc, rst_pc};

    always_ff @(posedge qclk) begin
        if (reset) begin
            flags_written <= 1'b0;
        end else if (core_flag_wr || ring_flag_wr) begin
            flags_written <= 1'b1;
        end
    end

    // ==================================================
    // Flag outputs
    // ==================================================
    a_reset_flags: assert property (@(posedge qclk) disable iff (reset)
        !flags_written |-> (rst_pc == '0 && en_pc == '1))
        else $error("rst_pc or en_pc left its reset value before any flag write");

    a_core_flag: assert property (@(posedge qclk) disable iff (reset)
        core_flag_wr |=> flags[$past(core_addr[2:0])] == $past(core_wr_data[0]))
        else $error("Flag output does not follow the core write");

    a_ring_flag: assert property (@(posedge qclk) disable iff (reset)
        ring_flag_wr |=> flags[$past(ring_addr[2:0])] == $past(ring_wr_data[0]))
        else $error("Flag output does not follow the ring write");

    // ==================================================
    // Quiet and unmapped reads
    // ==================================================
    a_core_quiet: assert property (@(posedge qclk) disable iff (reset)
        !core_rd_live |=> core_rd_data == '0)
        else $error("core_rd_data not zero after a quiet or unmapped read");

    a_ring_quiet: assert property (@(posedge qclk) disable iff (reset)
        !ring_rd_live |=> ring_rd_data == '0)
        else $error("ring_rd_data not zero after a quiet or unmapped read");

endmodule

bind cr_mem cr_mem_chk chk_i (.*);

/* verification/cr_mem_tb.sv */
`timescale 1ns/1ps

module cr_mem_tb;
    import cr_map_pkg::*;
    import thread_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;                // Sequence runs a few hundred cycles

    logic                   qclk;
    logic                   reset;
    logic [7:0]             core_id;
    cr_addr_t               core_addr;
    cr_data_t               core_wr_data;
    logic                   core_rd_en;
    logic                   core_wr_en;
    cr_data_t               core_rd_data;
    thread_oh_t             thread;
    cr_data_t               pc;
    cr_addr_t               ring_addr;
    cr_data_t               ring_wr_data;
    logic                   ring_rd_en;
    logic                   ring_wr_en;
    cr_data_t               ring_rd_data;
    logic [NUM_THREADS-1:0] rst_pc;
    logic [NUM_THREADS-1:0] en_pc;

    int       seed = 42;
    int       cycles = 0;
    cr_data_t regs_m [cr_addr_t];                        // Expected writable registers
    cr_data_t pc_m [NUM_THREADS];                        // Expected sampled PCs

    cr_mem #(.MSB_I_MEM(8'h3F), .MSB_D_MEM(8'h7F)) cr_mem_i (.*);

    initial begin
        qclk = 1'b0;
        forever #10 qclk = ~qclk;
    end

    always @(posedge qclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", cycles);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    // Current thread is the select rotated one place up
    function automatic int cur_thread(input thread_oh_t t);
        case ({t[2:0], t[3]})
            4'b0001: return 0;
            4'b0010: return 1;
            4'b0100: return 2;
            default: return 3;
        endcase
    endfunction

    function automatic void store(input cr_addr_t addr, input cr_data_t word);
        regs_m[addr] = (addr[15:3] == 13'h0002) ? {31'b0, word[0]} : word;  // Flags keep bit 0
    endfunction

    task automatic check_word(input string name, input cr_data_t got, input cr_data_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Register value mismatch");
        end
    endtask

    // One strobe on one port, a read is checked one cycle later
    task automatic access(input logic use_ring, input logic wr, input cr_addr_t addr,
                          input cr_data_t word);
        if (use_ring) begin
            ring_addr    = addr;
            ring_wr_data = word;
            ring_wr_en   = wr;
            ring_rd_en   = !wr;
        end else begin
            core_addr    = addr;
            core_wr_data = word;
            core_wr_en   = wr;
            core_rd_en   = !wr;
        end
        if (wr) begin
            store(addr, word);
        end
        @(negedge qclk);
        {core_rd_en, core_wr_en, ring_rd_en, ring_wr_en} = '0;
        if (!wr) begin
            check_word(use_ring ? "ring_rd_data" : "core_rd_data",
                       use_ring ? ring_rd_data : core_rd_data, word);
        end
    endtask

    initial begin
        int id;
        reset        = 1'b1;
        core_id      = 8'h00;
        core_addr    = '0;
        core_wr_data = '0;
        thread       = 4'b0001;
        pc           = '0;
        ring_addr    = '0;
        ring_wr_data = '0;
        {core_rd_en, core_wr_en, ring_rd_en, ring_wr_en} = '0;
        for (int n = 0; n < NUM_THREADS; n++) begin
            regs_m[THREAD0_PC_RST + cr_addr_t'(n)]       = 32'h0;
            regs_m[THREAD0_PC_EN + cr_addr_t'(n)]        = 32'h1;
            regs_m[THREAD0_STACK_OFFSET + cr_addr_t'(n)] = 32'h0040_0000 + 32'h200 * (n + 1);
            regs_m[THREAD0_TLS_OFFSET + cr_addr_t'(n)]   = 32'h0040_0000 + 32'h200 * (n + 1);
            regs_m[SCRATCHPAD0 + cr_addr_t'(n)]          = 32'h0;
        end
        regs_m[SHARED_BASE_OFFSET] = 32'h0040_0F00;
        repeat (8) @(negedge qclk);
        reset = 1'b0;

        // ==================================================
        // Reset values seen through the current thread
        // ==================================================
        for (int n = 0; n < NUM_THREADS; n++) begin
            thread = thread_oh_t'(1 << n);
            @(negedge qclk);
            id = cur_thread(thread);
            access(1'b0, 1'b0, STACK_BASE_OFFSET, regs_m[THREAD0_STACK_OFFSET + cr_addr_t'(id)]);
            access(1'b0, 1'b0, TLS_BASE_OFFSET, regs_m[THREAD0_TLS_OFFSET + cr_addr_t'(id)]);
            access(1'b1, 1'b0, SCRATCHPAD0 + cr_addr_t'(n), 32'h0);
        end
        access(1'b0, 1'b0, SHARED_BASE_OFFSET, 32'h0040_0F00);

        // Every writable register from the core port first, then from the ring
        for (int p = 0; p < 2; p++) begin
            for (int a = 'h10; a < 'h28; a++) begin
                if (a < 'h20 || a >= 'h24) begin
                    access(p[0], 1'b1, cr_addr_t'(a), $random(seed));
                    access(p[0], 1'b0, cr_addr_t'(a), regs_m[cr_addr_t'(a)]);
                end
            end
            access(p[0], 1'b1, SHARED_BASE_OFFSET, $random(seed));
            access(p[0], 1'b0, SHARED_BASE_OFFSET, regs_m[SHARED_BASE_OFFSET]);
        end

        // ==================================================
        // Collisions and simultaneous reads
        // ==================================================
        core_addr    = SCRATCHPAD0 + 16'd2;              // Same pad on both ports
        core_wr_data = $random(seed);
        core_wr_en   = 1'b1;
        store(core_addr, core_wr_data);
        access(1'b1, 1'b1, SCRATCHPAD0 + 16'd2, $random(seed));
        access(1'b0, 1'b0, SCRATCHPAD0 + 16'd2, regs_m[SCRATCHPAD0 + 16'd2]);
        core_addr    = SCRATCHPAD0;                      // Different registers in one cycle
        core_wr_data = $random(seed);
        core_wr_en   = 1'b1;
        store(core_addr, core_wr_data);
        access(1'b1, 1'b1, THREAD0_TLS_OFFSET + 16'd1, $random(seed));
        core_addr  = SCRATCHPAD0;
        core_rd_en = 1'b1;
        access(1'b1, 1'b0, THREAD0_TLS_OFFSET + 16'd1, regs_m[THREAD0_TLS_OFFSET + 16'd1]);
        check_word("core_rd_data", core_rd_data, regs_m[SCRATCHPAD0]);
        @(negedge qclk);
        check_word("core_rd_data", core_rd_data, '0);   // Quiet cycle
        check_word("ring_rd_data", ring_rd_data, '0);

        // ==================================================
        // Thread tracking and PC sampling
        // ==================================================
        core_id = 8'($random(seed));
        for (int i = 0; i < 2 * NUM_THREADS; i++) begin
            thread   = thread_oh_t'(1 << (i % NUM_THREADS));
            pc       = $random(seed);
            id       = cur_thread(thread);
            pc_m[id] = pc;
            @(negedge qclk);
            access(1'b0, 1'b0, THREAD_ID, cr_data_t'(id));
            access(1'b1, 1'b0, WHO_AM_I, {22'b0, core_id, 2'(id)});
            access(1'b0, 1'b0, THREAD0_PC + cr_addr_t'(id), pc_m[id]);
            access(1'b1, 1'b0, STACK_BASE_OFFSET, regs_m[THREAD0_STACK_OFFSET + cr_addr_t'(id)]);
            access(1'b0, 1'b0, TLS_BASE_OFFSET, regs_m[THREAD0_TLS_OFFSET + cr_addr_t'(id)]);
        end
        access(1'b1, 1'b0, CORE_ID, cr_data_t'(core_id));
        for (int n = 0; n < NUM_THREADS; n++) begin
            access(1'b1, 1'b0, THREAD0_PC + cr_addr_t'(n), pc_m[n]);
        end

        // Unmapped address and writes to read-only registers
        access(1'b0, 1'b0, 16'h00FF, '0);
        access(1'b0, 1'b1, I_MEM_MSB, $random(seed));
        access(1'b1, 1'b1, D_MEM_MSB, $random(seed));
        access(1'b1, 1'b0, I_MEM_MSB, 32'h0000_003F);
        access(1'b0, 1'b0, D_MEM_MSB, 32'h0000_007F);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* build.f */
rtl/cr_map_pkg.sv
rtl/thread_pkg.sv
rtl/thread_reg_bank.sv
rtl/cr_write_decode.sv
rtl/thread_snapshot.sv
rtl/cr_general_regs.sv
rtl/cr_read_port.sv
rtl/cr_mem.sv
verification/cr_mem_chk.sv
verification/cr_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cr_mem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# The run may stop on an assertion; the log search decides the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
